// ==== Bender.yml ====
package:
  name: dram_axi_bridge

sources:
  - files:
      - source/axi_pkg.sv
      - source/dram_pkg.sv
      - source/axi_req_capture.sv
      - source/dram_cmd_seq.sv
      - source/axi_resp_drive.sv
      - source/dram_axi_bridge.sv
  - target: test
    files:
      - verif/dram_model.sv
      - verif/tb_dram_axi_bridge.sv

# Simulation top: tb_dram_axi_bridge
# Synthesis top: dram_axi_bridge

// ==== list.f ====
source/axi_pkg.sv
source/dram_pkg.sv
source/axi_req_capture.sv
source/dram_cmd_seq.sv
source/axi_resp_drive.sv
source/dram_axi_bridge.sv
verif/dram_model.sv
verif/tb_dram_axi_bridge.sv

// ==== source/axi_pkg.sv ====
package axi_pkg;

  // AXI slave port widths
  localparam int axi_id_bits   = 8;
  localparam int axi_addr_bits = 32;
  localparam int axi_data_bits = 32;
  localparam int axi_len_bits  = 8;

  // One strobe per data byte
  localparam int axi_strb_bits = 4;

  localparam int axi_resp_bits = 2;

  // Only OKAY is ever returned
  localparam logic [axi_resp_bits-1:0] axi_resp_okay = 2'b00;

endpackage

// ==== source/axi_req_capture.sv ====
module axi_req_capture (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                arvalid,
  output logic                                arready,
  input  logic [axi_pkg::axi_addr_bits-1:0]   araddr,
  input  logic [axi_pkg::axi_id_bits-1:0]     arid,
  input  logic [axi_pkg::axi_len_bits-1:0]    arlen,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [axi_pkg::axi_addr_bits-1:0]   awaddr,
  input  logic [axi_pkg::axi_id_bits-1:0]     awid,
  input  logic                                wvalid,
  output logic                                wready,
  input  logic [axi_pkg::axi_data_bits-1:0]   wdata,
  input  logic [axi_pkg::axi_strb_bits-1:0]   wstrb,
  input  logic                                seq_idle,
  output logic                                req_start,
  output logic                                req_write,
  output dram_pkg::dram_addr_u                req_addr,
  output logic [axi_pkg::axi_id_bits-1:0]     req_id,
  output logic [axi_pkg::axi_len_bits-1:0]    req_len,
  output logic [axi_pkg::axi_data_bits-1:0]   req_wdata,
  output logic [axi_pkg::axi_strb_bits-1:0]   req_wstrb
);

  logic armed;
  logic ar_hs;
  logic aw_hs;

  // Write address and data only go together
  assign awready = armed && seq_idle && awvalid && wvalid;
  assign wready  = awready;

  // Reads yield to a pending write
  assign arready = armed && seq_idle && !awvalid;

  assign ar_hs = arvalid && arready;
  assign aw_hs = awvalid && awready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      armed     <= 1'b0;
      req_start <= 1'b0;
      req_write <= 1'b0;
    end else begin
      // Ready stays low until the first edge out of reset
      armed     <= 1'b1;
      req_start <= ar_hs || aw_hs;
      if (ar_hs || aw_hs) begin
        req_write <= aw_hs;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      req_addr.flat <= awaddr;
      req_id        <= awid;
      // Single beat write
      req_len       <= '0;
      req_wdata     <= wdata;
      req_wstrb     <= wstrb;
    end else if (ar_hs) begin
      req_addr.flat <= araddr;
      req_id        <= arid;
      req_len       <= arlen;
    end
  end

endmodule

// ==== source/axi_resp_drive.sv ====
module axi_resp_drive (
  input  logic                                 clk,
  input  logic                                 rstn,
  input  logic                                 req_start,
  input  logic [axi_pkg::axi_id_bits-1:0]      req_id,
  input  logic [axi_pkg::axi_len_bits-1:0]     req_len,
  input  logic                                 rd_phase,
  input  logic                                 b_pend,
  input  logic [dram_pkg::dram_data_bits-1:0]  dram_q,
  input  logic                                 dram_valid,
  input  logic                                 rready,
  input  logic                                 bready,
  output logic                                 rvalid,
  output logic                                 rlast,
  output logic [axi_pkg::axi_id_bits-1:0]      rid,
  output logic [axi_pkg::axi_data_bits-1:0]    rdata,
  output logic [axi_pkg::axi_resp_bits-1:0]    rresp,
  output logic                                 bvalid,
  output logic [axi_pkg::axi_id_bits-1:0]      bid,
  output logic [axi_pkg::axi_resp_bits-1:0]    bresp,
  output logic [axi_pkg::axi_len_bits-1:0]     beat_idx,
  output logic                                 burst_done,
  output logic                                 b_done
);

  import axi_pkg::*;

  logic r_hs;

  // Read data comes straight off the DRAM
  assign rvalid = rd_phase && dram_valid;
  assign rdata  = dram_q;
  assign rid    = req_id;
  assign rresp  = axi_resp_okay;
  assign rlast  = (beat_idx == req_len);

  assign r_hs       = rvalid && rready;
  assign burst_done = r_hs && rlast;

  assign bvalid = b_pend;
  assign bid    = req_id;
  assign bresp  = axi_resp_okay;
  assign b_done = bvalid && bready;

  // Beat counter also serves as the column offset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_idx <= '0;
    end else if (req_start) begin
      beat_idx <= '0;
    end else if (r_hs) begin
      beat_idx <= beat_idx + 1'b1;
    end
  end

endmodule

// ==== source/dram_axi_bridge.sv ====
module dram_axi_bridge (
  input  logic                                 clk,
  input  logic                                 rstn,
  input  logic                                 arvalid,
  output logic                                 arready,
  input  logic [axi_pkg::axi_addr_bits-1:0]    araddr,
  input  logic [axi_pkg::axi_id_bits-1:0]      arid,
  input  logic [axi_pkg::axi_len_bits-1:0]     arlen,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [axi_pkg::axi_addr_bits-1:0]    awaddr,
  input  logic [axi_pkg::axi_id_bits-1:0]      awid,
  input  logic                                 wvalid,
  output logic                                 wready,
  input  logic [axi_pkg::axi_data_bits-1:0]    wdata,
  input  logic [axi_pkg::axi_strb_bits-1:0]    wstrb,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic                                 rlast,
  output logic [axi_pkg::axi_id_bits-1:0]      rid,
  output logic [axi_pkg::axi_data_bits-1:0]    rdata,
  output logic [axi_pkg::axi_resp_bits-1:0]    rresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  output logic [axi_pkg::axi_id_bits-1:0]      bid,
  output logic [axi_pkg::axi_resp_bits-1:0]    bresp,
  input  logic [dram_pkg::dram_data_bits-1:0]  dram_q,
  input  logic                                 dram_valid,
  output logic                                 dram_csn,
  output logic                                 dram_rasn,
  output logic                                 dram_casn,
  output logic [dram_pkg::web_bits-1:0]        dram_wen,
  output logic [dram_pkg::dram_a_bits-1:0]     dram_a,
  output logic [dram_pkg::dram_data_bits-1:0]  dram_d
);

  import axi_pkg::*;
  import dram_pkg::*;

  logic                     req_start;
  logic                     req_write;
  dram_addr_u               req_addr;
  logic [axi_id_bits-1:0]   req_id;
  logic [axi_len_bits-1:0]  req_len;
  logic [axi_data_bits-1:0] req_wdata;
  logic [axi_strb_bits-1:0] req_wstrb;
  logic                     seq_idle;
  logic                     rd_phase;
  logic                     b_pend;
  logic [axi_len_bits-1:0]  beat_idx;
  logic                     burst_done;
  logic                     b_done;

  axi_req_capture req_capture_inst (
    .clk       (clk),
    .rstn      (rstn),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .arid      (arid),
    .arlen     (arlen),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .awid      (awid),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .seq_idle  (seq_idle),
    .req_start (req_start),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_id    (req_id),
    .req_len   (req_len),
    .req_wdata (req_wdata),
    .req_wstrb (req_wstrb)
  );

  dram_cmd_seq cmd_seq_inst (
    .clk        (clk),
    .rstn       (rstn),
    .req_start  (req_start),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_len    (req_len),
    .req_wdata  (req_wdata),
    .req_wstrb  (req_wstrb),
    .beat_idx   (beat_idx),
    .burst_done (burst_done),
    .b_done     (b_done),
    .seq_idle   (seq_idle),
    .rd_phase   (rd_phase),
    .b_pend     (b_pend),
    .dram_csn   (dram_csn),
    .dram_rasn  (dram_rasn),
    .dram_casn  (dram_casn),
    .dram_wen   (dram_wen),
    .dram_a     (dram_a),
    .dram_d     (dram_d)
  );

  axi_resp_drive resp_drive_inst (
    .clk        (clk),
    .rstn       (rstn),
    .req_start  (req_start),
    .req_id     (req_id),
    .req_len    (req_len),
    .rd_phase   (rd_phase),
    .b_pend     (b_pend),
    .dram_q     (dram_q),
    .dram_valid (dram_valid),
    .rready     (rready),
    .bready     (bready),
    .rvalid     (rvalid),
    .rlast      (rlast),
    .rid        (rid),
    .rdata      (rdata),
    .rresp      (rresp),
    .bvalid     (bvalid),
    .bid        (bid),
    .bresp      (bresp),
    .beat_idx   (beat_idx),
    .burst_done (burst_done),
    .b_done     (b_done)
  );

endmodule

// ==== source/dram_cmd_seq.sv ====
module dram_cmd_seq (
  input  logic                                 clk,
  input  logic                                 rstn,
  input  logic                                 req_start,
  input  logic                                 req_write,
  input  dram_pkg::dram_addr_u                 req_addr,
  input  logic [axi_pkg::axi_len_bits-1:0]     req_len,
  input  logic [dram_pkg::dram_data_bits-1:0]  req_wdata,
  input  logic [dram_pkg::web_bits-1:0]        req_wstrb,
  input  logic [axi_pkg::axi_len_bits-1:0]     beat_idx,
  input  logic                                 burst_done,
  input  logic                                 b_done,
  output logic                                 seq_idle,
  output logic                                 rd_phase,
  output logic                                 b_pend,
  output logic                                 dram_csn,
  output logic                                 dram_rasn,
  output logic                                 dram_casn,
  output logic [dram_pkg::web_bits-1:0]        dram_wen,
  output logic [dram_pkg::dram_a_bits-1:0]     dram_a,
  output logic [dram_pkg::dram_data_bits-1:0]  dram_d
);

  import dram_pkg::*;

  dram_state_t           state;
  dram_state_t           state_nxt;
  dram_state_t           access_st;
  logic [row_bits-1:0]   open_row;
  logic                  row_open;
  logic                  row_hit;
  logic [t_rcd_bits-1:0] rcd_cnt;
  logic                  rcd_done;
  logic [col_bits-1:0]   col;

  assign row_hit   = row_open && (open_row == req_addr.fields.row);
  assign access_st = req_write ? st_write : st_read;
  assign rcd_done  = (rcd_cnt == t_rcd_bits'(t_rcd - 1));

  // Column walks with the accepted beats
  assign col       = req_addr.fields.col + col_bits'(beat_idx);

  // Request is latched but not yet seen by the FSM while req_start is high
  assign seq_idle = (state == st_idle) && !req_start;
  assign rd_phase = (state == st_read);
  assign b_pend   = (state == st_write_resp);

  assign dram_csn = cs_enb;
  assign dram_d   = req_wdata;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (req_start) begin
          if (row_hit) begin
            state_nxt = access_st;
          end else if (row_open) begin
            state_nxt = st_pre;
          end else begin
            state_nxt = st_act;
          end
        end
      end
      st_pre:        state_nxt = st_act;
      st_act:        state_nxt = st_wait_rcd;
      st_wait_rcd:   if (rcd_done) state_nxt = access_st;
      st_read:       if (burst_done) state_nxt = st_idle;
      st_write:      state_nxt = st_write_resp;
      st_write_resp: if (b_done) state_nxt = st_idle;
      default:       state_nxt = st_idle;
    endcase
  end

  // Open row bookkeeping and tRCD wait
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      row_open <= 1'b0;
      rcd_cnt  <= '0;
    end else begin
      if (state == st_pre) begin
        row_open <= 1'b0;
      end else if (state == st_act) begin
        row_open <= 1'b1;
      end
      if (state == st_act) begin
        rcd_cnt <= '0;
      end else if (rcd_cnt != t_rcd_bits'(t_rcd)) begin
        rcd_cnt <= rcd_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_act) begin
      open_row <= req_addr.fields.row;
    end
  end

  always_comb begin
    dram_rasn = ras_dis;
    dram_casn = cas_dis;
    dram_wen  = {web_bits{web_dis}};
    dram_a    = dram_a_bits'(col);
    case (state)
      st_pre: begin
        // Precharge is RAS with every WEn low
        dram_rasn = ras_enb;
        dram_wen  = {web_bits{web_enb}};
        dram_a    = dram_a_bits'(open_row);
      end
      st_act: begin
        dram_rasn = ras_enb;
        dram_a    = dram_a_bits'(req_addr.fields.row);
      end
      st_read: begin
        dram_casn = cas_enb;
      end
      st_write: begin
        dram_casn = cas_enb;
        dram_wen  = (web_enb == 1'b1) ? req_wstrb : ~req_wstrb;
      end
      default: ;
    endcase
  end

endmodule

// ==== source/dram_pkg.sv ====
package dram_pkg;

  // Single bank geometry
  localparam int row_bits       = 11;
  localparam int col_bits       = 10;
  localparam int dram_a_bits    = 11;
  localparam int web_bits       = 4;
  localparam int dram_data_bits = 32;

  // Strobes are all active low
  localparam logic cs_enb  = 1'b0;
  localparam logic cs_dis  = 1'b1;
  localparam logic ras_enb = 1'b0;
  localparam logic ras_dis = 1'b1;
  localparam logic cas_enb = 1'b0;
  localparam logic cas_dis = 1'b1;
  localparam logic web_enb = 1'b0;
  localparam logic web_dis = 1'b1;

  // Activate to CAS, in clock cycles
  localparam int t_rcd      = 3;
  localparam int t_rcd_bits = $clog2(t_rcd + 1);

  typedef enum logic [6:0] {
    st_idle       = 7'b000_0001,
    st_pre        = 7'b000_0010,
    st_act        = 7'b000_0100,
    st_wait_rcd   = 7'b000_1000,
    st_read       = 7'b001_0000,
    st_write      = 7'b010_0000,
    st_write_resp = 7'b100_0000
  } dram_state_t;

  // Byte address as seen by the bank
  typedef union packed {
    logic [31:0] flat;
    struct packed {
      logic [8:0]          unused;
      logic [row_bits-1:0] row;
      logic [col_bits-1:0] col;
      logic [1:0]          byte_off;
    } fields;
  } dram_addr_u;

endpackage

// ==== verif/dram_model.sv ====
module dram_model (
  input  logic                                 clk,
  input  logic                                 rstn,
  input  logic                                 csn,
  input  logic                                 rasn,
  input  logic                                 casn,
  input  logic [dram_pkg::web_bits-1:0]        wen,
  input  logic [dram_pkg::dram_a_bits-1:0]     a,
  input  logic [dram_pkg::dram_data_bits-1:0]  d,
  output logic [dram_pkg::dram_data_bits-1:0]  q,
  output logic                                 valid,
  output int                                   act_count
);

  import dram_pkg::*;

  logic [dram_data_bits-1:0] mem [int];
  logic [row_bits-1:0]       row;
  logic                      row_open;
  int                        mem_rev = 0;
  logic                      sel;
  logic                      do_pre;
  logic                      do_act;
  logic                      do_cas;
  logic                      do_wr;

  assign sel    = (csn == cs_enb);
  assign do_pre = sel && rasn == ras_enb && casn == cas_dis && wen == {web_bits{web_enb}};
  assign do_act = sel && rasn == ras_enb && casn == cas_dis && wen == {web_bits{web_dis}};
  assign do_cas = sel && rasn == ras_dis && casn == cas_enb;
  assign do_wr  = do_cas && wen != {web_bits{web_dis}};

  function automatic int key_of(input logic [row_bits-1:0] r, input logic [dram_a_bits-1:0] c);
    return int'({r, c[col_bits-1:0]});
  endfunction

  // Untouched words read back as a pattern of their own address
  function automatic logic [dram_data_bits-1:0] fill_word(input int k);
    return 32'ha500_0000 ^ {k[20:0], k[10:0]};
  endfunction

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      row_open  <= 1'b0;
      row       <= '0;
      act_count <= 0;
    end else if (do_pre) begin
      row_open <= 1'b0;
    end else if (do_act) begin
      row_open  <= 1'b1;
      row       <= a[row_bits-1:0];
      act_count <= act_count + 1;
    end
  end

  // Byte enables are active low
  always @(posedge clk) begin : write_port
    int                        k;
    logic [dram_data_bits-1:0] w;
    if (rstn && do_wr && row_open) begin
      k = key_of(row, a);
      w = mem.exists(k) ? mem[k] : fill_word(k);
      for (int i = 0; i < web_bits; i++) begin
        if (wen[i] == web_enb) begin
          w[8*i +: 8] = d[8*i +: 8];
        end
      end
      mem[k]  = w;
      mem_rev = mem_rev + 1;
    end
  end

  always @(do_cas or wen or a or row or row_open or mem_rev) begin : read_port
    int k;
    k     = key_of(row, a);
    valid = do_cas && row_open && wen == {web_bits{web_dis}};
    q     = mem.exists(k) ? mem[k] : fill_word(k);
  end

endmodule

// ==== verif/tb_dram_axi_bridge.sv ====
module tb_dram_axi_bridge;

  import axi_pkg::*;
  import dram_pkg::*;

  localparam int clk_period      = 40;
  localparam int reset_cycles    = 16;
  localparam int n_tests         = 12;
  localparam int cycles_per_test = 200;

  logic clk = 1'b0;
  logic rstn;
  logic arvalid, arready, awvalid, awready, wvalid, wready;
  logic rvalid, rready, rlast, bvalid, bready;
  logic [axi_addr_bits-1:0]  araddr, awaddr;
  logic [axi_id_bits-1:0]    arid, awid, rid, bid;
  logic [axi_len_bits-1:0]   arlen;
  logic [axi_data_bits-1:0]  wdata, rdata;
  logic [axi_strb_bits-1:0]  wstrb;
  logic [axi_resp_bits-1:0]  rresp, bresp;
  logic [dram_data_bits-1:0] dram_q, dram_d;
  logic                      dram_valid, dram_csn, dram_rasn, dram_casn;
  logic [web_bits-1:0]       dram_wen;
  logic [dram_a_bits-1:0]    dram_a;
  int                        act_count;

  // Stimulus table, one entry per test
  string                    t_name  [n_tests];
  logic                     t_write [n_tests];
  logic [axi_addr_bits-1:0] t_addr  [n_tests];
  logic [axi_data_bits-1:0] t_data  [n_tests];
  logic [axi_strb_bits-1:0] t_strb  [n_tests];
  logic [axi_len_bits-1:0]  t_len   [n_tests];
  logic [axi_id_bits-1:0]   t_id    [n_tests];
  logic [31:0]              t_stall [n_tests];

  logic [axi_data_bits-1:0] sb [int];
  integer seed;
  int     n_added;
  int     test_errs;
  int     pass_cnt;
  int     fail_cnt;

  dram_axi_bridge dram_axi_bridge_inst (.*);

  dram_model dram_model_inst (
    .clk       (clk),
    .rstn      (rstn),
    .csn       (dram_csn),
    .rasn      (dram_rasn),
    .casn      (dram_casn),
    .wen       (dram_wen),
    .a         (dram_a),
    .d         (dram_d),
    .q         (dram_q),
    .valid     (dram_valid),
    .act_count (act_count)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic int key_of(input logic [axi_addr_bits-1:0] addr);
    dram_addr_u u;
    u.flat = addr;
    return int'({u.fields.row, u.fields.col});
  endfunction

  // Same pattern the DRAM model returns for untouched words
  function automatic logic [31:0] sb_read(input logic [axi_addr_bits-1:0] addr);
    int k;
    k = key_of(addr);
    return sb.exists(k) ? sb[k] : 32'ha500_0000 ^ {k[20:0], k[10:0]};
  endfunction

  task automatic sb_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    logic [31:0] w;
    w = sb_read(addr);
    for (int i = 0; i < axi_strb_bits; i++) begin
      if (strb[i]) w[8*i +: 8] = data[8*i +: 8];
    end
    sb[key_of(addr)] = w;
  endtask

  task automatic add_test(input string name, input logic wr, input int row, input int col,
                          input logic [31:0] data, input logic [3:0] strb,
                          input int len, input logic [7:0] id);
    dram_addr_u u;
    u.flat         = '0;
    u.fields.row   = row[row_bits-1:0];
    u.fields.col   = col[col_bits-1:0];
    t_name[n_added]  = name;
    t_write[n_added] = wr;
    t_addr[n_added]  = u.flat;
    t_data[n_added]  = data;
    t_strb[n_added]  = strb;
    t_len[n_added]   = len[axi_len_bits-1:0];
    t_id[n_added]    = id;
    // Every fourth cycle ready is forced so a burst always moves on
    t_stall[n_added] = $random(seed) & 32'h7777_7777;
    n_added++;
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic run_write(input int i);
    int   cyc;
    logic hs;
    @(negedge clk);
    awvalid = 1'b1;
    awaddr  = t_addr[i];
    awid    = t_id[i];
    wvalid  = 1'b1;
    wdata   = t_data[i];
    wstrb   = t_strb[i];
    #1;
    while (!awready) begin
      @(negedge clk);
      #1;
    end
    // Address and data are taken on the same edge
    check_value(t_name[i], "wready", 1'b1, wready);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    sb_write(t_addr[i], t_data[i], t_strb[i]);
    cyc = 0;
    hs  = 1'b0;
    while (!hs) begin
      bready = !t_stall[i][cyc % 32];
      #1;
      hs = bvalid && bready;
      if (!hs) @(negedge clk);
      cyc++;
    end
    check_value(t_name[i], "bid", t_id[i], bid);
    check_value(t_name[i], "bresp", axi_resp_okay, bresp);
  endtask

  task automatic run_read(input int i);
    int cyc;
    int beat;
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = t_addr[i];
    arid    = t_id[i];
    arlen   = t_len[i];
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    beat = 0;
    cyc  = 0;
    while (beat <= int'(t_len[i])) begin
      rready = !t_stall[i][cyc % 32];
      #1;
      if (rvalid && rready) begin
        check_value(t_name[i], $sformatf("rdata[%0d]", beat),
                    sb_read(t_addr[i] + 4 * beat), rdata);
        check_value(t_name[i], $sformatf("rlast[%0d]", beat), beat == int'(t_len[i]), rlast);
        check_value(t_name[i], "rid", t_id[i], rid);
        check_value(t_name[i], "rresp", axi_resp_okay, rresp);
        beat++;
      end
      @(negedge clk);
      cyc++;
    end
    rready = 1'b1;
    #1;
    assert (!rvalid) else begin
      $display("%s: read data kept coming after the last beat", t_name[i]);
      test_errs++;
    end
  endtask

  initial begin
    #((reset_cycles + n_tests * cycles_per_test) * clk_period);
    $display("Watchdog expired before all tests finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    dram_addr_u u;
    int         prev_row;
    int         exp_act;
    rstn    = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    arid    = '0;
    arlen   = '0;
    awvalid = 1'b0;
    awaddr  = '0;
    awid    = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    rready  = 1'b0;
    bready  = 1'b0;
    seed    = 10846;
    n_added = 0;
    add_test("wr_full",    1'b1,   5,  16, 32'hcafe_f00d, 4'hf,    0, 8'h11);
    add_test("rd_full",    1'b0,   5,  16, 32'h0,         4'h0,    0, 8'h22);
    add_test("wr_part",    1'b1,   5,  16, 32'h1234_5678, 4'b0101, 0, 8'h33);
    add_test("rd_part",    1'b0,   5,  16, 32'h0,         4'h0,    0, 8'h44);
    add_test("wr_next",    1'b1,   5,  17, 32'h0bad_beef, 4'hf,    0, 8'h55);
    add_test("wr_row9",    1'b1,   9,   3, 32'hdead_c0de, 4'b1010, 0, 8'h66);
    add_test("rd_row9",    1'b0,   9,   3, 32'h0,         4'h0,    0, 8'h77);
    add_test("burst_r5",   1'b0,   5,  14, 32'h0,         4'h0,    7, 8'h88);
    add_test("burst_16",   1'b0, 200, 100, 32'h0,         4'h0,   15, 8'h99);
    add_test("wr_row200",  1'b1, 200, 101, 32'h5a5a_3c3c, 4'b1100, 0, 8'haa);
    add_test("burst_r200", 1'b0, 200,  98, 32'h0,         4'h0,    5, 8'hbb);
    add_test("burst_r0",   1'b0,   0,   0, 32'h0,         4'h0,    3, 8'hcc);
    repeat (reset_cycles) @(negedge clk);
    rstn = 1'b1;
    prev_row = -1;
    pass_cnt = 0;
    fail_cnt = 0;
    for (int i = 0; i < n_tests; i++) begin
      u.flat    = t_addr[i];
      exp_act   = act_count + ((prev_row != int'(u.fields.row)) ? 1 : 0);
      test_errs = 0;
      if (t_write[i]) begin
        run_write(i);
      end else begin
        run_read(i);
      end
      check_value(t_name[i], "act_count", exp_act, act_count);
      prev_row = int'(u.fields.row);
      if (test_errs == 0) begin
        $display("%-12s ok", t_name[i]);
        pass_cnt++;
      end else begin
        $display("%-12s FAILED with %0d errors", t_name[i], test_errs);
        fail_cnt++;
      end
    end
    $display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
